// ==== all.f ====
design/routerPkg.sv
design/flitChannel.sv
design/inputQueue.sv
design/grantTimer.sv
design/switchArbiter.sv
design/outputSwitch.sv
design/routerOutputPort.sv
testbench/clockGen.sv
testbench/routerOutputPortTb.sv

// ==== Makefile ====
TOOL  := verilator
FLAGS := --binary --timing -j 0
TOP   := routerOutputPortTb
FLIST := all.f
BUILD := obj_dir
LOG   := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "No errors" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== testbench/routerOutputPortTb.sv ====
`default_nettype none

module routerOutputPortTb;
  import routerPkg::*;

  localparam int queueDepth = 4;
  localparam int testFlits = 3 + 9 + 6 + numPorts * 12 + queueDepth + 1;
  localparam int maxCycles = 8 * testFlits + 100;  // Room for stalls and budget idles.

  logic clk;
  logic rst;
  logic [numPorts-1:0] inValid;
  flitT inFlit [numPorts];
  logic [numPorts-1:0] inReady;
  logic outValid;
  flitT outFlit;
  logic outReady;
  grantT grant;

  flitT src [numPorts][$];
  flitT modelQ [numPorts][$];
  logic [lengthW-1:0] refBudget [numPorts];
  logic [lengthW-1:0] refCount [numPorts];
  logic [11:0] seqIn [numPorts];
  logic [numPorts-1:0] accepted;
  grantT mGrant;
  grantT prevGrant;
  flitT prevFlit;
  logic prevStall;
  logic [31:0] lfsr = 32'h193b9893;
  logic inStall;
  logic outRandom;
  logic outFixed;
  string testName;
  int checks;
  int errors;
  int cycles;

  clockGen #(
    .period(8),
    .resetCycles(10)
  ) clock_i (
    .clk(clk),
    .rst(rst)
  );

  routerOutputPort #(
    .queueDepth(queueDepth)
  ) dut_i (
    .clk(clk),
    .rst(rst),
    .inValid(inValid),
    .inFlit(inFlit),
    .inReady(inReady),
    .outValid(outValid),
    .outFlit(outFlit),
    .outReady(outReady),
    .grant(grant)
  );

  function automatic logic takeBit();
    lfsr = (lfsr >> 1) ^ ({32{lfsr[0]}} & 32'h80200003);
    return lfsr[0];
  endfunction

  // Stay while the holder has work and budget, else search the ports after it.
  function automatic grantT refNextGrant(grantT cur, logic [numPorts-1:0] req,
                                         logic [numPorts-1:0] up);
    int h;
    int c;
    h = -1;
    for (int p = 0; p < numPorts; p++)
    begin
      if (cur[p + 1])
      begin
        h = p;
      end
    end
    if (h >= 0 && req[h] && !up[h])
    begin
      return cur;
    end
    for (int k = 1; k <= numPorts; k++)
    begin
      c = (h + k) % numPorts;  // From idle this walks L, N, E, W, S.
      if (req[c] && c != h)
      begin
        return grantT'(1) << (c + 1);
      end
    end
    return grantT'(1);
  endfunction

  task automatic checkGrant(string what, grantT exp, grantT act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("Mismatch %s %s expected %h actual %h", testName, what, exp, act);
    end
  endtask

  task automatic checkFlit(string what, flitT exp, flitT act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("Mismatch %s %s expected %h actual %h", testName, what, exp, act);
    end
  endtask

  task automatic checkBits(string what, logic [numPorts-1:0] exp, logic [numPorts-1:0] act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("Mismatch %s %s expected %b actual %b", testName, what, exp, act);
    end
  endtask

  task automatic checkValid(string what, logic exp, logic act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("Mismatch %s %s expected %b actual %b", testName, what, exp, act);
    end
  endtask

  task automatic finishRun();
    $display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
    if (errors == 0)
    begin
      $display("No errors");
    end
    else
    begin
      $display("Errors found");
    end
    $finish;
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic offer(int p, int n, logic [lengthW-1:0] len);
    flitT f;
    for (int i = 0; i < n; i++)
    begin
      f.kind = (i == 0) ? kindHead : ((i == n - 1) ? kindTail : kindBody);
      f.length = (i == 0) ? len : '0;
      f.data = {4'(p), seqIn[p]};  // Source port over sequence number.
      seqIn[p]++;
      src[p].push_back(f);
    end
  endtask

  task automatic step();
    @(negedge clk);
    for (int p = 0; p < numPorts; p++)
    begin
      if (accepted[p])
      begin
        src[p].delete(0);
      end
      if (!inValid[p] || accepted[p])
      begin
        inValid[p] = (src[p].size() != 0) && !(inStall && takeBit());
        if (src[p].size() != 0)
        begin
          inFlit[p] = src[p][0];
        end
      end
    end
    outReady = outRandom ? takeBit() : outFixed;
  endtask

  function automatic logic drained();
    for (int p = 0; p < numPorts; p++)
    begin
      if (src[p].size() != 0 || modelQ[p].size() != 0)
      begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic waitDrained();
    do
    begin
      step();
    end
    while (!drained());
  endtask

  ////////////////////////////////////////
  // Reference model and compare
  ////////////////////////////////////////

  always @(posedge clk)
  begin : referenceModel
    logic [numPorts-1:0] req;
    logic [numPorts-1:0] up;
    logic [numPorts-1:0] expReady;
    logic expValid;
    grantT expNext;
    int h;
    if (rst)
    begin
      mGrant = grantT'(1);
      prevStall = 1'b0;
      accepted = '0;
      for (int p = 0; p < numPorts; p++)
      begin
        modelQ[p].delete();
        refBudget[p] = '0;
        refCount[p] = '0;
      end
    end
    else
    begin
      h = -1;
      for (int p = 0; p < numPorts; p++)
      begin
        req[p] = modelQ[p].size() != 0;
        up[p] = refCount[p] == refBudget[p];
        expReady[p] = modelQ[p].size() < queueDepth;
        if (mGrant[p + 1])
        begin
          h = p;
        end
      end
      expValid = (h >= 0) && req[h];
      checkGrant("grant", mGrant, grant);
      checkBits("inReady", expReady, inReady);
      checkValid("outValid", expValid, outValid);
      if (expValid)
      begin
        checkFlit("outFlit", modelQ[h][0], outFlit);
      end
      if (prevStall && mGrant == prevGrant)
      begin
        checkFlit("heldFlit", prevFlit, outFlit);  // Back-pressure must not disturb the flit.
      end
      prevStall = expValid && !outReady;
      if (expValid)
      begin
        prevFlit = modelQ[h][0];
      end
      prevGrant = mGrant;
      expNext = refNextGrant(mGrant, req, up);
      for (int p = 0; p < numPorts; p++)
      begin
        if (req[p] && modelQ[p][0].kind == kindHead)
        begin
          refBudget[p] = modelQ[p][0].length;
        end
        refCount[p] = (p == h && expNext == mGrant) ? refCount[p] + 1'b1 : '0;
        accepted[p] = inValid[p] && expReady[p];
      end
      if (expValid && outReady)
      begin
        modelQ[h].delete(0);
      end
      for (int p = 0; p < numPorts; p++)
      begin
        if (accepted[p])
        begin
          modelQ[p].push_back(inFlit[p]);
        end
      end
      mGrant = expNext;
    end
    cycles++;
    if (cycles >= maxCycles)
    begin
      errors++;
      $display("Timeout after %0d cycles, the traffic never drained", cycles);
      finishRun();
    end
  end

  initial
  begin
    inValid = '0;
    outReady = 1'b0;
    accepted = '0;
    for (int p = 0; p < numPorts; p++)
    begin
      inFlit[p] = '0;
      seqIn[p] = '0;
    end
    inStall = 1'b0;
    outRandom = 1'b0;
    outFixed = 1'b1;
    checks = 0;
    errors = 0;
    cycles = 0;
    testName = "resetIdle";
    wait (!rst);
    repeat (3) step();
    checkGrant("grant", grantT'(1), grant);
    checkBits("inReady", '1, inReady);
    testName = "priority";
    offer(portNorth, 1, 0);
    offer(portEast, 1, 0);
    offer(portSouth, 1, 0);
    while (grant == grantT'(1)) step();
    checkGrant("firstGrant", 6'b000100, grant);  // North wins over East and South.
    waitDrained();
    testName = "budget";
    offer(portWest, 6, 2);
    offer(portSouth, 3, 0);
    waitDrained();
    testName = "release";
    offer(portLocal, 2, 7);
    offer(portNorth, 2, 7);
    offer(portWest, 2, 7);
    waitDrained();
    testName = "random";
    inStall = 1'b1;
    outRandom = 1'b1;
    for (int k = 0; k < 3; k++)
    begin
      for (int p = 0; p < numPorts; p++)
      begin
        offer(p, 4, lengthW'(p + k));
      end
    end
    waitDrained();
    inStall = 1'b0;
    outRandom = 1'b0;
    testName = "fullQueue";
    outFixed = 1'b0;
    offer(portEast, queueDepth + 1, 1);
    while (src[portEast].size() > 1) step();
    checkBits("inReady", 5'b11011, inReady);
    outFixed = 1'b1;
    while (!inReady[portEast]) step();
    waitDrained();
    finishRun();
  end

endmodule

`default_nettype wire

// ==== testbench/clockGen.sv ====
`default_nettype none

module clockGen #(
  parameter int period = 8,
  parameter int resetCycles = 10
) (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(period / 2) clk = ~clk;
    end
  end

  initial
  begin
    rst = 1'b1;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;  // Released on a falling edge like the other inputs.
  end

endmodule

`default_nettype wire

// ==== design/routerOutputPort.sv ====
`default_nettype none

module routerOutputPort #(
  parameter int queueDepth = 4
) (
  input logic clk,
  input logic rst,
  input logic [routerPkg::numPorts-1:0] inValid,
  input routerPkg::flitT inFlit [routerPkg::numPorts],
  output logic [routerPkg::numPorts-1:0] inReady,
  output logic outValid,
  output routerPkg::flitT outFlit,
  input logic outReady,
  output routerPkg::grantT grant
);
  import routerPkg::*;

  flitChannel inCh [numPorts] ();
  flitChannel frontCh [numPorts] ();
  flitChannel outCh ();

  logic [numPorts-1:0] req;
  flitKindT frontKind [numPorts];
  logic [lengthW-1:0] frontLength [numPorts];

  ////////////////////////////////////////
  // Input queues
  ////////////////////////////////////////

  for (genvar p = 0; p < numPorts; p++)
  begin : portSlice
    assign inCh[p].valid = inValid[p];
    assign inCh[p].flit = inFlit[p];
    assign inReady[p] = inCh[p].ready;

    inputQueue #(
      .depth(queueDepth)
    ) queue_i (
      .clk(clk),
      .rst(rst),
      .enq(inCh[p]),
      .deq(frontCh[p])
    );

    assign req[p] = frontCh[p].valid;  // A non-empty queue requests.
    assign frontKind[p] = frontCh[p].flit.kind;
    assign frontLength[p] = frontCh[p].flit.length;
  end

  ////////////////////////////////////////
  // Arbitration and switching
  ////////////////////////////////////////

  switchArbiter arbiter_i (
    .clk(clk),
    .rst(rst),
    .req(req),
    .frontKind(frontKind),
    .frontLength(frontLength),
    .grant(grant)
  );

  outputSwitch switch_i (
    .grant(grant),
    .front(frontCh),
    .out(outCh)
  );

  assign outValid = outCh.valid;
  assign outFlit = outCh.flit;
  assign outCh.ready = outReady;

endmodule

`default_nettype wire

// ==== design/outputSwitch.sv ====
`default_nettype none

module outputSwitch (
  input routerPkg::grantT grant,
  flitChannel.sink front [routerPkg::numPorts],
  flitChannel.source out
);
  import routerPkg::*;

  logic [numPorts-1:0] frontValid;
  flitT frontFlit [numPorts];

  ////////////////////////////////////////
  // Queue fronts
  ////////////////////////////////////////

  for (genvar p = 0; p < numPorts; p++)
  begin : frontTap
    assign frontValid[p] = front[p].valid;
    assign frontFlit[p] = front[p].flit;
    // Only the granted queue sees the output's ready, so only it pops.
    assign front[p].ready = grant[p + 1] & out.ready;
  end

  ////////////////////////////////////////
  // Output mux
  ////////////////////////////////////////

  always_comb
  begin
    out.valid = 1'b0;  // Idle grant leaves the output quiet.
    out.flit = '0;
    for (int p = 0; p < numPorts; p++)
    begin
      if (grant[p + 1])
      begin
        out.valid = frontValid[p];
        out.flit = frontFlit[p];
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/switchArbiter.sv ====
`default_nettype none

module switchArbiter (
  input logic clk,
  input logic rst,
  input logic [routerPkg::numPorts-1:0] req,
  input routerPkg::flitKindT frontKind [routerPkg::numPorts],
  input logic [routerPkg::lengthW-1:0] frontLength [routerPkg::numPorts],
  output routerPkg::grantT grant
);
  import routerPkg::*;

  grantT nextGrant;
  portIdxT holder;
  logic holderValid;
  logic [numPorts-1:0] runTimer;
  logic [numPorts-1:0] timesUp;
  flitKindT seenKind [numPorts];

  ////////////////////////////////////////
  // Per-input grant timers
  ////////////////////////////////////////

  // An empty queue shows no flit, so its stale front cannot reload a budget.
  always_comb
  begin
    for (int p = 0; p < numPorts; p++)
    begin
      if (req[p])
      begin
        seenKind[p] = frontKind[p];
      end
      else
      begin
        seenKind[p] = kindIdle;
      end
    end
  end

  for (genvar p = 0; p < numPorts; p++)
  begin : timerSlice
    grantTimer timer_i (
      .clk(clk),
      .rst(rst),
      .frontKind(seenKind[p]),
      .frontLength(frontLength[p]),
      .runTimer(runTimer[p]),
      .timesUp(timesUp[p])
    );
  end

  ////////////////////////////////////////
  // Grant state
  ////////////////////////////////////////

  always_comb
  begin
    holderValid = 1'b0;
    holder = portLocal;
    for (int p = 0; p < numPorts; p++)
    begin
      if (grant[p + 1])
      begin
        holderValid = 1'b1;
        holder = portIdxT'(p);
      end
    end
  end

  // Stay while the holder requests and has budget, else search after it.
  always_comb
  begin : nextStateLogic
    int base;
    int cand;
    logic found;
    nextGrant = grantIdle;
    runTimer = '0;
    found = 1'b0;
    base = 0;
    if (holderValid)
    begin
      base = int'(holder) + 1;  // Rotated order starts after the holder.
    end
    if (holderValid && req[holder] && !timesUp[holder])
    begin
      nextGrant = grant;
      runTimer[holder] = 1'b1;
      found = 1'b1;
    end
    for (int k = 0; k < numPorts; k++)
    begin
      cand = (base + k) % numPorts;
      if (!found && req[cand] && !(holderValid && cand == int'(holder)))
      begin
        nextGrant = grantOf(portIdxT'(cand));
        found = 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant <= grantIdle;
    end
    else
    begin
      grant <= nextGrant;  // A lone expired holder passes through idle.
    end
  end

endmodule

`default_nettype wire

// ==== design/grantTimer.sv ====
`default_nettype none

module grantTimer (
  input logic clk,
  input logic rst,
  input routerPkg::flitKindT frontKind,
  input logic [routerPkg::lengthW-1:0] frontLength,
  input logic runTimer,
  output logic timesUp
);
  import routerPkg::*;

  logic [lengthW-1:0] budget;
  logic [lengthW-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      budget <= '0;
      count <= '0;
    end
    else
    begin
      if (frontKind == kindHead)
      begin
        budget <= frontLength;  // Latest head at the front sets the budget.
      end
      if (runTimer)
      begin
        count <= count + 1'b1;
      end
      else
      begin
        count <= '0;
      end
    end
  end

  // Count runs from zero, so the holder gets budget plus one cycles.
  assign timesUp = (count == budget);

endmodule

`default_nettype wire

// ==== design/inputQueue.sv ====
`default_nettype none

module inputQueue #(
  parameter int depth = 4
) (
  input logic clk,
  input logic rst,
  flitChannel.sink enq,
  flitChannel.source deq
);
  import routerPkg::*;

  localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
  localparam logic [ptrW-1:0] lastPtr = (ptrW)'(depth - 1);
  localparam logic [ptrW:0] fullCount = (ptrW + 1)'(depth);

  flitT mem [depth];
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [ptrW:0] count;
  logic push;
  logic pop;

  assign enq.ready = (count != fullCount);  // Refuses only when full.
  assign push = enq.valid & enq.ready;

  assign deq.valid = (count != '0);
  assign deq.flit = mem[rdPtr];
  assign pop = deq.valid & deq.ready;

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wrPtr] <= enq.flit;
    end
  end

  ////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
      begin
        wrPtr <= (wrPtr == lastPtr) ? '0 : wrPtr + 1'b1;  // Wraps for any depth.
      end
      if (pop)
      begin
        rdPtr <= (rdPtr == lastPtr) ? '0 : rdPtr + 1'b1;
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;  // Both or neither leave the level unchanged.
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/flitChannel.sv ====
`default_nettype none

interface flitChannel;
  import routerPkg::*;

  logic valid;
  logic ready;
  flitT flit;  // Held stable while valid is high and ready is low.

  modport source (
    output valid,
    output flit,
    input  ready
  );

  modport sink (
    input  valid,
    input  flit,
    output ready
  );

endinterface

`default_nettype wire

// ==== design/routerPkg.sv ====
`default_nettype none

package routerPkg;

  ////////////////////////////////////////
  // Router geometry and field widths
  ////////////////////////////////////////

  localparam int numPorts = 5;
  localparam int lengthW = 12;
  localparam int dataW = 16;

  typedef enum logic [2:0] {
    portLocal = 3'd0,
    portNorth = 3'd1,
    portEast  = 3'd2,
    portWest  = 3'd3,
    portSouth = 3'd4
  } portIdxT;

  ////////////////////////////////////////
  // Flit format
  ////////////////////////////////////////

  typedef enum logic [2:0] {
    kindIdle = 3'd0,
    kindHead = 3'd1,  // Carries the packet budget in length.
    kindBody = 3'd2,
    kindTail = 3'd3
  } flitKindT;

  typedef struct packed {
    flitKindT kind;
    logic [lengthW-1:0] length;
    logic [dataW-1:0] data;
  } flitT;

  ////////////////////////////////////////
  // Output grant state
  ////////////////////////////////////////

  // Bit 0 is idle, bits 1 to 5 follow the port order.
  typedef logic [numPorts:0] grantT;

  localparam grantT grantIdle = grantT'(1);

  function automatic grantT grantOf(portIdxT port);
    return grantT'(1) << (int'(port) + 1);
  endfunction

endpackage

`default_nettype wire
